/* include/spi_slave_settings.svh */
`ifndef SPI_SLAVE_SETTINGS_SVH
`define SPI_SLAVE_SETTINGS_SVH

// APB side
`define SPI_DATA_W      32

// widest character in bits
`define SPI_CHAR_MAX    16

// flops on each SPI pin before use
`define SPI_SYNC_STAGES 2

// byte addresses on the 4-bit APB address
`define SPI_ADDR_CTRL   4'h0
`define SPI_ADDR_STATUS 4'h4
`define SPI_ADDR_TXDATA 4'h8
`define SPI_ADDR_RXDATA 4'hC

`endif

/* logic/spi_apb_regs.sv */
`include "spi_slave_settings.svh"

module spi_apb_regs import spi_slave_pkg::*; (
    input  logic                   S_REV,
    input  logic                   S_RESETN,
    input  spi_addr_t              paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`SPI_DATA_W-1:0] pwdata,
    output logic [`SPI_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    output spi_mode_t              mode,
    output spi_char_t              tx_char,
    input  spi_char_t              rx_char,
    input  logic                   char_done,
    input  logic                   tx_taken
);

    localparam int MODE_W = $bits(spi_mode_t);

    logic      access;
    logic      addr_hit;
    logic      wr_en;
    logic      rd_en;
    spi_char_t tx_data;
    spi_char_t rx_data;
    logic      rx_valid;
    logic      tx_empty;
    logic      overrun;

    assign access   = psel && penable;
    assign addr_hit = paddr inside {`SPI_ADDR_CTRL, `SPI_ADDR_STATUS,
                                    `SPI_ADDR_TXDATA, `SPI_ADDR_RXDATA};
    assign wr_en    = access && pwrite && addr_hit;
    assign rd_en    = access && !pwrite && addr_hit;

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access && !addr_hit;
    assign irq     = rx_valid;
    assign tx_char = tx_empty ? '1 : tx_data;  // empty buffer sends ones

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            mode     <= '0;
            rx_valid <= 1'b0;
            tx_empty <= 1'b1;
            overrun  <= 1'b0;
        end else begin
            if (wr_en && paddr == `SPI_ADDR_CTRL) begin
                mode <= spi_mode_t'(pwdata[MODE_W-1:0]);
            end
            if (wr_en && paddr == `SPI_ADDR_STATUS && pwdata[2]) begin
                overrun <= 1'b0;  // write one to clear
            end
            if (rd_en && paddr == `SPI_ADDR_RXDATA) begin
                rx_valid <= 1'b0;
            end
            // a completing character wins over the read and the clear
            if (char_done) begin
                rx_valid <= 1'b1;
                if (rx_valid) begin
                    overrun <= 1'b1;
                end
            end
            if (tx_taken) begin
                tx_empty <= 1'b1;
            end
            if (wr_en && paddr == `SPI_ADDR_TXDATA) begin
                tx_empty <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_REV) begin
        if (wr_en && paddr == `SPI_ADDR_TXDATA) begin
            tx_data <= pwdata[`SPI_CHAR_MAX-1:0];
        end
        if (char_done) begin
            rx_data <= rx_char;
        end
    end

    // STATUS is {overrun, tx_empty, rx_valid}, TXDATA reads as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            `SPI_ADDR_CTRL: begin
                prdata[MODE_W-1:0] = mode;
            end
            `SPI_ADDR_STATUS: begin
                prdata[2:0] = {overrun, tx_empty, rx_valid};
            end
            `SPI_ADDR_RXDATA: begin
                prdata[`SPI_CHAR_MAX-1:0] = rx_data;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

/* logic/spi_bit_counter.sv */
module spi_bit_counter import spi_slave_pkg::*; (
    input  logic      S_REV,
    input  logic      S_RESETN,
    input  spi_mode_t mode,
    spi_char_if.cnt   bus
);

    spi_len_t bit_cnt;  // bits sampled so far

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            bit_cnt <= '0;
        end else if (bus.load) begin
            bit_cnt <= '0;
        end else if (bus.sample) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // high while the next sample is the final one
    assign bus.last_bit = (bit_cnt == mode.char_len);

endmodule

/* logic/spi_char_fsm.sv */
module spi_char_fsm import spi_slave_pkg::*; (
    input  logic       S_REV,
    input  logic       S_RESETN,
    input  spi_mode_t  mode,
    spi_char_if.ctl    bus,
    output logic       char_done,
    output logic       tx_taken,
    output spi_state_t state
);

    spi_state_t state_nxt;
    logic       active;
    logic       sample_edge;
    logic       shift_edge;
    logic       sampled;   // a bit was already taken in this character

    assign active      = mode.enable && bus.cs_active;
    assign sample_edge = mode.cpha ? bus.sck_trail : bus.sck_lead;
    assign shift_edge  = mode.cpha ? bus.sck_lead : bus.sck_trail;

    assign bus.load   = (state == LOAD);
    assign bus.sample = (state == XFER) && sample_edge;
    // no shift before the first sample, keeps bit 0 on miso
    assign bus.shift  = (state == XFER) && shift_edge && sampled;
    assign tx_taken   = (state == LOAD);
    assign char_done  = (state == DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (active) begin
                    state_nxt = LOAD;
                end
            end
            LOAD: begin
                state_nxt = active ? XFER : IDLE;
            end
            XFER: begin
                if (!active) begin
                    state_nxt = IDLE;  // aborted, no char_done
                end else if (bus.sample && bus.last_bit) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = active ? LOAD : IDLE;  // back to back under cs
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state   <= IDLE;
            sampled <= 1'b0;
        end else begin
            state <= state_nxt;
            if (bus.load) begin
                sampled <= 1'b0;
            end else if (bus.sample) begin
                sampled <= 1'b1;
            end
        end
    end

endmodule

/* logic/spi_char_if.sv */
interface spi_char_if import spi_slave_pkg::*; ();

    logic      sck_lead;   // sck left its idle level
    logic      sck_trail;  // sck back to idle level
    logic      cs_active;
    logic      sample;
    logic      shift;
    logic      load;
    logic      last_bit;
    spi_char_t rx_char;

    modport pins (
        output sck_lead, sck_trail, cs_active, rx_char,
        input  sample, shift, load
    );

    modport ctl (
        input  sck_lead, sck_trail, cs_active, last_bit,
        output sample, shift, load
    );

    modport cnt (
        input  sample, load,
        output last_bit
    );

endinterface

/* logic/spi_pin_shifter.sv */
`include "spi_slave_settings.svh"

module spi_pin_shifter import spi_slave_pkg::*; (
    input  logic      S_REV,
    input  logic      S_RESETN,
    input  logic      spi_sck,
    input  logic      spi_cs_n,
    input  logic      spi_mosi,
    output logic      spi_miso,
    input  spi_mode_t mode,
    input  spi_char_t tx_char,
    spi_char_if.pins  bus
);

    logic [`SPI_SYNC_STAGES-1:0] sck_sync;
    logic [`SPI_SYNC_STAGES-1:0] cs_sync;
    logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
    logic                        sck_s;
    logic                        sck_q;   // edge register
    logic                        mosi_s;
    spi_char_t                   tx_sr;
    spi_char_t                   rx_sr;
    spi_char_t                   len_mask;

    // reverse the low len+1 bits, clear the rest
    function automatic spi_char_t flip(spi_char_t value, spi_len_t len);
        spi_char_t res;
        res = '0;
        for (int i = 0; i < `SPI_CHAR_MAX; i++) begin
            if (i <= len) begin
                res[i] = value[len - i];
            end
        end
        return res;
    endfunction

    assign sck_s         = sck_sync[`SPI_SYNC_STAGES-1];
    assign mosi_s        = mosi_sync[`SPI_SYNC_STAGES-1];
    assign bus.cs_active = ~cs_sync[`SPI_SYNC_STAGES-1];

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_sync      <= '0;
            cs_sync       <= '1;
            mosi_sync     <= '0;
            sck_q         <= 1'b0;
            bus.sck_lead  <= 1'b0;
            bus.sck_trail <= 1'b0;
        end else begin
            sck_sync      <= {sck_sync[`SPI_SYNC_STAGES-2:0], spi_sck};
            cs_sync       <= {cs_sync[`SPI_SYNC_STAGES-2:0], spi_cs_n};
            mosi_sync     <= {mosi_sync[`SPI_SYNC_STAGES-2:0], spi_mosi};
            sck_q         <= sck_s;
            bus.sck_lead  <= (sck_s != sck_q) && (sck_s != mode.cpol);
            bus.sck_trail <= (sck_s != sck_q) && (sck_s == mode.cpol);
        end
    end

    // always shifts left, miso taken from bit char_len
    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            tx_sr <= '1;
        end else if (bus.load) begin
            tx_sr <= mode.lsb_first ? flip(tx_char, mode.char_len) : tx_char;
        end else if (bus.shift) begin
            tx_sr <= {tx_sr[`SPI_CHAR_MAX-2:0], 1'b1};  // fill with idle ones
        end
    end

    always_ff @(posedge S_REV) begin
        if (bus.load) begin
            rx_sr <= '0;
        end else if (bus.sample) begin
            rx_sr <= {rx_sr[`SPI_CHAR_MAX-2:0], mosi_s};
        end
    end

    always_comb begin
        for (int i = 0; i < `SPI_CHAR_MAX; i++) begin
            len_mask[i] = (i <= mode.char_len);
        end
    end

    // first received bit sits at char_len
    assign bus.rx_char = mode.lsb_first ? flip(rx_sr, mode.char_len) : (rx_sr & len_mask);

    assign spi_miso = (bus.cs_active && mode.enable) ? tx_sr[mode.char_len] : 1'b1;

endmodule

/* logic/spi_slave_pkg.sv */
`include "spi_slave_settings.svh"

package spi_slave_pkg;

    typedef logic [`SPI_CHAR_MAX-1:0] spi_char_t;  // right aligned

    typedef logic [3:0] spi_len_t;  // length minus one

    typedef logic [3:0] spi_addr_t;

    // CTRL[7:0] layout
    typedef struct packed {
        logic     enable;     // bit 7
        logic     cpol;
        logic     cpha;
        logic     lsb_first;
        spi_len_t char_len;   // bits 3:0
    } spi_mode_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        XFER = 2'd2,
        DONE = 2'd3
    } spi_state_t;

endpackage

/* logic/spi_slave_top.sv */
`include "spi_slave_settings.svh"

module spi_slave_top import spi_slave_pkg::*; (
    input  logic                   S_REV,
    input  logic                   S_RESETN,
    // APB
    input  spi_addr_t              paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`SPI_DATA_W-1:0] pwdata,
    output logic [`SPI_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    // SPI
    input  logic                   spi_sck,
    input  logic                   spi_cs_n,
    input  logic                   spi_mosi,
    output logic                   spi_miso
);

    spi_mode_t mode;
    spi_char_t tx_char;
    logic      char_done;
    logic      tx_taken;

    spi_char_if i_char_if ();

    spi_pin_shifter i_pin_shifter (
        .S_REV    (S_REV),
        .S_RESETN (S_RESETN),
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .mode     (mode),
        .tx_char  (tx_char),
        .bus      (i_char_if.pins)
    );

    spi_bit_counter i_bit_counter (
        .S_REV    (S_REV),
        .S_RESETN (S_RESETN),
        .mode     (mode),
        .bus      (i_char_if.cnt)
    );

    spi_char_fsm i_char_fsm (
        .S_REV     (S_REV),
        .S_RESETN  (S_RESETN),
        .mode      (mode),
        .bus       (i_char_if.ctl),
        .char_done (char_done),
        .tx_taken  (tx_taken),
        .state     ()           // observed by the bound checks
    );

    spi_apb_regs i_apb_regs (
        .S_REV     (S_REV),
        .S_RESETN  (S_RESETN),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .irq       (irq),
        .mode      (mode),
        .tx_char   (tx_char),
        .rx_char   (i_char_if.rx_char),
        .char_done (char_done),
        .tx_taken  (tx_taken)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module spi_slave_tb -f sources.f -o spi_slave_sim

out=$(./obj_dir/spi_slave_sim) || true
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* sources.f */
+incdir+include
logic/spi_slave_pkg.sv
logic/spi_char_if.sv
logic/spi_pin_shifter.sv
logic/spi_bit_counter.sv
logic/spi_char_fsm.sv
logic/spi_apb_regs.sv
logic/spi_slave_top.sv
tests/spi_slave_asserts.sv
tests/spi_slave_tb.sv

/* tests/spi_slave_asserts.sv */
module spi_slave_asserts import spi_slave_pkg::*; #(
    parameter bit FSM_SIDE = 1'b1  // state machine side or register side
) (
    input logic       S_REV,
    input logic       S_RESETN,
    input spi_state_t state,
    input logic       cs_active,
    input logic       char_done,
    input logic       sample,
    input logic       shift,
    input logic       pready
);

    if (FSM_SIDE) begin : g_fsm

        // DONE lasts one cycle, then reload or idle
        char_done_pulse: assert property (@(posedge S_REV) disable iff (!S_RESETN)
            char_done |=> !char_done)
            else $error("char_done high for more than one cycle");

        idle_without_cs: assert property (@(posedge S_REV) disable iff (!S_RESETN)
            !cs_active |=> state == IDLE)
            else $error("state machine busy while chip select is inactive");

        strobes_apart: assert property (@(posedge S_REV) disable iff (!S_RESETN)
            !(sample && shift))
            else $error("sample and shift in the same cycle");

    end else begin : g_regs

        pready_high: assert property (@(posedge S_REV) disable iff (!S_RESETN)
            pready)
            else $error("pready dropped");

    end

endmodule

bind spi_char_fsm spi_slave_asserts #(.FSM_SIDE(1'b1)) i_fsm_asserts (
    .S_REV     (S_REV),
    .S_RESETN  (S_RESETN),
    .state     (state),
    .cs_active (bus.cs_active),
    .char_done (char_done),
    .sample    (bus.sample),
    .shift     (bus.shift),
    .pready    ()
);

// register side only checks pready
bind spi_apb_regs spi_slave_asserts #(.FSM_SIDE(1'b0)) i_regs_asserts (
    .S_REV     (S_REV),
    .S_RESETN  (S_RESETN),
    .state     (),
    .cs_active (),
    .char_done (),
    .sample    (),
    .shift     (),
    .pready    (pready)
);

/* tests/spi_slave_tb.sv */
`include "spi_slave_settings.svh"

module spi_slave_tb import spi_slave_pkg::*; ();

    localparam int HALF_CLKS  = 8;     // sck half period in S_REV clocks
    localparam int N_CHARS    = 60;
    localparam int IRQ_LIMIT  = 1000;  // clocks
    localparam int POLL_LIMIT = 40;    // STATUS reads

    logic                   S_REV;
    logic                   S_RESETN;
    spi_addr_t              paddr;
    logic                   psel, penable, pwrite;
    logic [`SPI_DATA_W-1:0] pwdata;
    logic [`SPI_DATA_W-1:0] prdata;
    logic                   pready, pslverr, irq;
    logic                   spi_sck, spi_cs_n, spi_mosi, spi_miso;

    integer    seed;
    spi_mode_t cfg;            // mode the master runs in
    spi_char_t mosi_words[4];
    spi_char_t miso_words[4];  // as collected by the master

    spi_slave_top i_spi_slave_top (.*);

    always #20 S_REV = ~S_REV;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_char(input string name, input spi_char_t got, input spi_char_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic spi_char_t char_mask(input spi_len_t len);
        return spi_char_t'((32'd1 << (len + 1)) - 32'd1);
    endfunction

    // word bit that travels at a given step of the character
    function automatic int wire_pos(input int step);
        return cfg.lsb_first ? step : int'(cfg.char_len) - step;
    endfunction

    task automatic apb_write(input spi_addr_t addr, input logic [`SPI_DATA_W-1:0] data);
        @(posedge S_REV);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge S_REV);
        penable <= 1'b1;
        @(posedge S_REV);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input spi_addr_t addr, output logic [`SPI_DATA_W-1:0] data,
                            output logic err);
        @(posedge S_REV);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge S_REV);
        penable <= 1'b1;
        @(negedge S_REV);  // mid access phase
        data = prdata;
        err  = pslverr;
        check_flag("pready", pready, 1'b1);
        @(posedge S_REV);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_status(input logic rx_valid, input logic tx_empty, input logic overrun);
        logic [`SPI_DATA_W-1:0] data;
        logic                   err;
        apb_read(`SPI_ADDR_STATUS, data, err);
        check_flag("rx_valid", data[0], rx_valid);
        check_flag("tx_empty", data[1], tx_empty);
        check_flag("overrun", data[2], overrun);
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (irq !== 1'b1 && waited < IRQ_LIMIT) begin
            @(negedge S_REV);
            waited++;
        end
        if (irq !== 1'b1) begin
            $display("timeout waiting for irq after a character");
            abort_run();
        end
    endtask

    task automatic wait_overrun();
        logic [`SPI_DATA_W-1:0] data;
        logic                   err;
        int                     tries;
        data  = '0;
        tries = 0;
        while (!data[2] && tries < POLL_LIMIT) begin
            apb_read(`SPI_ADDR_STATUS, data, err);
            tries++;
        end
        if (!data[2]) begin
            $display("overrun was not set by a second unread character");
            abort_run();
        end
    endtask

    // n characters back to back under one chip select
    task automatic spi_burst(input int n);
        spi_char_t got;
        @(posedge S_REV);
        spi_sck <= cfg.cpol;  // idle level of this mode
        repeat (4) @(posedge S_REV);
        spi_cs_n <= 1'b0;
        spi_mosi <= mosi_words[0][wire_pos(0)];
        for (int c = 0; c < n; c++) begin
            got = '0;
            for (int b = 0; b <= int'(cfg.char_len); b++) begin
                repeat (HALF_CLKS) @(posedge S_REV);
                if (cfg.cpha) begin
                    spi_mosi <= mosi_words[c][wire_pos(b)];
                end else begin
                    got[wire_pos(b)] = spi_miso;
                end
                spi_sck <= ~cfg.cpol;  // leading edge
                repeat (HALF_CLKS) @(posedge S_REV);
                if (cfg.cpha) begin
                    got[wire_pos(b)] = spi_miso;
                end else if (b < int'(cfg.char_len)) begin
                    spi_mosi <= mosi_words[c][wire_pos(b + 1)];
                end else if (c + 1 < n) begin
                    spi_mosi <= mosi_words[c + 1][wire_pos(0)];
                end
                spi_sck <= cfg.cpol;  // trailing edge
            end
            miso_words[c] = got;
        end
        repeat (HALF_CLKS) @(posedge S_REV);
        spi_cs_n <= 1'b1;
    endtask

    task automatic collect_rx(input int n);
        logic [`SPI_DATA_W-1:0] data;
        logic                   err;
        for (int c = 0; c < n; c++) begin
            wait_irq();
            apb_read(`SPI_ADDR_RXDATA, data, err);
            check_char("RXDATA", data[`SPI_CHAR_MAX-1:0],
                       mosi_words[c] & char_mask(cfg.char_len));
            @(negedge S_REV);
            check_flag("irq", irq, 1'b0);
        end
    endtask

    initial begin
        logic [`SPI_DATA_W-1:0] rdata;
        logic [31:0]            rnd;
        logic                   err;
        logic                   tx_written;
        spi_char_t              tx_word;
        spi_char_t              exp;
        int                     n;
        int                     chars;
        seed     = 32'h6114;
        S_REV    = 1'b0;
        S_RESETN = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        spi_sck  = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b1;
        cfg      = '0;
        repeat (5) @(posedge S_REV);
        S_RESETN <= 1'b1;
        @(negedge S_REV);
        check_flag("irq", irq, 1'b0);
        check_flag("spi_miso", spi_miso, 1'b1);
        check_status(1'b0, 1'b1, 1'b0);
        apb_read(4'h2, rdata, err);
        check_flag("pslverr", err, 1'b1);

        chars = 0;
        while (chars < N_CHARS) begin
            rnd = $random(seed);
            cfg.enable    = 1'b1;
            cfg.cpol      = rnd[0];
            cfg.cpha      = rnd[1];
            cfg.lsb_first = rnd[2];
            cfg.char_len  = spi_len_t'(3 + rnd[15:8] % 13);  // 4 to 16 bits
            n             = 1 + rnd[17:16] % 3;
            tx_written    = (rnd[20:18] != 3'd0);
            tx_word       = rnd[31:16];
            apb_write(`SPI_ADDR_CTRL, {24'h0, cfg});
            apb_read(`SPI_ADDR_CTRL, rdata, err);
            check_flag("pslverr", err, 1'b0);
            check_char("CTRL", rdata[`SPI_CHAR_MAX-1:0], {8'h00, cfg});
            for (int c = 0; c < n; c++) begin
                rnd = $random(seed);
                mosi_words[c] = rnd[15:0];
            end
            if (tx_written) begin
                apb_write(`SPI_ADDR_TXDATA, {16'h0, tx_word});
            end
            fork
                spi_burst(n);
                collect_rx(n);
            join
            for (int c = 0; c < n; c++) begin
                exp = char_mask(cfg.char_len);  // empty buffer sends ones
                if (c == 0 && tx_written) begin
                    exp = tx_word & exp;
                end
                check_char("MISO", miso_words[c], exp);
            end
            check_status(1'b0, 1'b1, 1'b0);
            chars += n;
        end

        // second character lands on an unread one
        rnd = $random(seed);
        mosi_words[0] = rnd[15:0];
        spi_burst(1);
        wait_irq();
        rnd = $random(seed);
        mosi_words[0] = rnd[15:0];
        spi_burst(1);
        wait_overrun();
        check_flag("irq", irq, 1'b1);
        apb_read(`SPI_ADDR_RXDATA, rdata, err);
        check_char("RXDATA", rdata[`SPI_CHAR_MAX-1:0], mosi_words[0] & char_mask(cfg.char_len));
        apb_write(`SPI_ADDR_STATUS, 32'h4);
        check_status(1'b0, 1'b1, 1'b0);
        @(negedge S_REV);
        check_flag("irq", irq, 1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
